// File: design/core_pkg.sv
package core_pkg;

	// bus word and address
	typedef logic [35:0] word_t;
	typedef logic [13:0] addr_t;	// 16k words per module
	typedef logic [3:0]  sel_t;	// module select code

	localparam int num_ports = 4;

	typedef logic [num_ports-1:0]         port_vec_t;	// one bit per processor port
	typedef logic [$clog2(num_ports)-1:0] port_idx_t;

	// phase lengths in clocks
	localparam int timer_w   = 4;
	localparam int t_ack     = 2;
	localparam int t_read    = 6;
	localparam int t_write   = 6;
	localparam int t_recover = 3;

	typedef enum logic [2:0] {
		IDLE,
		ACK,
		READ,
		STROBE,	// sense amplifier strobe
		WAIT_WR,	// waiting for the processor's write restart
		WRITE,
		RECOVER,
		STOPPED
	} cycle_state_t;

endpackage

// File: design/port_arbiter.sv
`timescale 1ns/100ps

module port_arbiter (
	input  logic                                     clk,
	input  logic                                     reset,
	input  core_pkg::port_vec_t                      rq_cyc,
	input  core_pkg::port_vec_t                      fmc_select,
	input  core_pkg::sel_t [core_pkg::num_ports-1:0] sel,
	input  core_pkg::sel_t                           my_sel,
	input  logic                                     await_rq,
	input  logic                                     release_cyc,
	output logic                                     grant,
	output core_pkg::port_vec_t                      active,
	output core_pkg::port_idx_t                      active_port
);
	import core_pkg::*;

	port_vec_t qual;
	port_idx_t pick_idx;
	logic      last3;	// set when port 3 was served last
	logic      take;

	always_comb begin
		for (int i = 0; i < num_ports; i++) begin
			qual[i] = rq_cyc[i] & ~fmc_select[i] & (sel[i] == my_sel);
		end
	end

	// 0 beats everyone, 1 beats 2 and 3, then 2 and 3 take turns
	always_comb begin
		if (qual[0]) begin
			pick_idx = 2'd0;
		end else if (qual[1]) begin
			pick_idx = 2'd1;
		end else if (qual[2] && (!qual[3] || last3)) begin
			pick_idx = 2'd2;
		end else begin
			pick_idx = 2'd3;
		end
	end

	// only one pick per memory cycle
	assign take = await_rq & ~(|active) & (|qual);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			grant       <= 1'b0;
			active      <= '0;
			active_port <= '0;
			last3       <= 1'b0;
		end else begin
			grant <= take;
			if (take) begin
				active      <= port_vec_t'(1) << pick_idx;
				active_port <= pick_idx;
				if (pick_idx[1]) begin
					last3 <= pick_idx[0];	// remember which of 2/3 went
				end
			end else if (release_cyc) begin
				active <= '0;
			end
		end
	end

endmodule

// File: design/cycle_timer.sv
`timescale 1ns/100ps

module cycle_timer (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         load,
	input  logic [core_pkg::timer_w-1:0] count,
	output logic                         done
);
	import core_pkg::*;

	logic [timer_w-1:0] cnt;
	logic               run;

	// done falls in the last clock of a phase of count clocks
	assign done = run & (cnt == '0);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cnt <= '0;
			run <= 1'b0;
		end else if (load) begin
			cnt <= count - 1'b1;
			run <= 1'b1;
		end else if (run) begin
			if (cnt == '0) begin
				run <= 1'b0;
			end else begin
				cnt <= cnt - 1'b1;
			end
		end
	end

endmodule

// File: design/cycle_control.sv
`timescale 1ns/100ps

module cycle_control (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         grant,
	input  core_pkg::port_vec_t          active,
	input  core_pkg::port_idx_t          active_port,
	input  core_pkg::port_vec_t          rd_rq,
	input  core_pkg::port_vec_t          wr_rq,
	input  core_pkg::port_vec_t          wr_rs,
	input  logic                         timer_done,
	input  logic                         sw_single_step,
	input  logic                         sw_restart,
	output logic                         await_rq,
	output logic                         release_cyc,
	output logic                         timer_load,
	output logic [core_pkg::timer_w-1:0] timer_count,
	output core_pkg::port_vec_t          addr_ack,
	output core_pkg::port_vec_t          rd_rs,
	output logic                         latch_addr,
	output logic                         strobe_sense,
	output logic                         capture_wr,
	output logic                         write_core,
	output logic                         restore
);
	import core_pkg::*;

	cycle_state_t state;
	cycle_state_t next;

	logic ack_q;	// first clock of ACK
	logic rd_rs_q;
	logic cyc_rd;
	logic cyc_wr;
	logic wr_seen;	// write restart already taken this cycle
	logic stop;
	logic restart_q;
	logic busy;
	logic wr_now;
	logic wr_go;
	logic restart_rise;

	assign busy         = (state != IDLE) && (state != STOPPED);
	assign wr_now       = wr_rs[active_port] & (|active);
	assign wr_go        = wr_seen | wr_now;
	assign restart_rise = sw_restart & ~restart_q;

	// processor may give its write restart any time after the acknowledge
	assign capture_wr = cyc_wr & wr_now & ~wr_seen & ~ack_q
		& (state inside {ACK, READ, STROBE, WAIT_WR});

	assign await_rq     = (state == IDLE);
	assign release_cyc  = (state == RECOVER) & timer_done;
	assign latch_addr   = ack_q;
	assign strobe_sense = (state == STROBE);
	assign write_core   = (state == WRITE) & timer_done;
	assign restore      = (state == WRITE) & ~cyc_wr;	// read only cycle puts the word back
	assign addr_ack     = active & {num_ports{ack_q}};
	assign rd_rs        = active & {num_ports{rd_rs_q}};

	always_comb begin
		next        = state;
		timer_load  = 1'b0;
		timer_count = timer_w'(t_ack);
		case (state)
			IDLE: begin
				if (grant) begin
					next       = ACK;
					timer_load = 1'b1;
				end
			end
			ACK: begin
				if (timer_done) begin
					next        = READ;
					timer_load  = 1'b1;
					timer_count = timer_w'(t_read);
				end
			end
			READ: begin
				if (timer_done) begin
					next = STROBE;
				end
			end
			STROBE: begin
				if (!cyc_wr || wr_seen) begin
					next        = WRITE;
					timer_load  = 1'b1;
					timer_count = timer_w'(t_write);
				end else begin
					next = WAIT_WR;
				end
			end
			WAIT_WR: begin
				if (wr_go) begin
					next        = WRITE;
					timer_load  = 1'b1;
					timer_count = timer_w'(t_write);
				end
			end
			WRITE: begin
				if (timer_done) begin
					next        = RECOVER;
					timer_load  = 1'b1;
					timer_count = timer_w'(t_recover);
				end
			end
			RECOVER: begin
				if (timer_done) begin
					next = (stop || sw_single_step) ? STOPPED : IDLE;
				end
			end
			STOPPED: begin
				if (restart_rise) begin
					next = IDLE;	// key restart
				end
			end
			default: next = IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state     <= IDLE;
			ack_q     <= 1'b0;
			rd_rs_q   <= 1'b0;
			cyc_rd    <= 1'b0;
			cyc_wr    <= 1'b0;
			wr_seen   <= 1'b0;
			stop      <= 1'b0;
			restart_q <= 1'b0;
		end else begin
			state     <= next;
			ack_q     <= (state == IDLE) & grant;
			rd_rs_q   <= (state == STROBE) & cyc_rd;	// sense is loaded by then
			restart_q <= sw_restart;
			if (ack_q) begin
				cyc_rd <= rd_rq[active_port];
				cyc_wr <= wr_rq[active_port];
			end
			if (grant) begin
				wr_seen <= 1'b0;
			end else if (capture_wr) begin
				wr_seen <= 1'b1;
			end
			if (grant) begin
				stop <= sw_single_step;
			end else if (busy && sw_single_step) begin
				stop <= 1'b1;
			end
		end
	end

endmodule

// File: design/core_array.sv
`timescale 1ns/100ps

module core_array (
	input  logic            clk,
	input  logic            reset,
	input  core_pkg::addr_t ma_sel,
	input  core_pkg::word_t mb_sel,
	input  logic            latch_addr,
	input  logic            strobe_sense,
	input  logic            capture_wr,
	input  logic            write_core,
	input  logic            restore,
	output core_pkg::word_t sense
);
	import core_pkg::*;

	word_t core [0:(1 << $bits(addr_t)) - 1];
	addr_t cma;	// memory address register
	word_t cmb;	// memory buffer

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cma   <= '0;
			sense <= '0;
		end else begin
			if (latch_addr) begin
				cma <= ma_sel;
			end
			if (strobe_sense) begin
				sense <= core[cma];
			end
		end
	end

	// write data from the processor wins over the restore path
	always_ff @(posedge clk) begin
		if (capture_wr) begin
			cmb <= mb_sel;
		end else if (restore) begin
			cmb <= sense;
		end
	end

	always_ff @(posedge clk) begin
		if (write_core) begin
			core[cma] <= cmb;
		end
	end

endmodule

// File: design/core_memory.sv
`timescale 1ns/100ps

module core_memory #(
	parameter core_pkg::sel_t mem_select = 4'd0	// jumper code of this module
) (
	input  logic                                      clk,
	input  logic                                      reset,
	input  logic                                      sw_single_step,
	input  logic                                      sw_restart,
	input  core_pkg::port_vec_t                       rq_cyc,
	input  core_pkg::port_vec_t                       rd_rq,
	input  core_pkg::port_vec_t                       wr_rq,
	input  core_pkg::port_vec_t                       wr_rs,
	input  core_pkg::port_vec_t                       fmc_select,
	input  core_pkg::sel_t  [core_pkg::num_ports-1:0] sel,
	input  core_pkg::addr_t [core_pkg::num_ports-1:0] ma,
	input  core_pkg::word_t [core_pkg::num_ports-1:0] mb_in,
	output core_pkg::port_vec_t                       addr_ack,
	output core_pkg::port_vec_t                       rd_rs,
	output core_pkg::word_t [core_pkg::num_ports-1:0] mb_out
);
	import core_pkg::*;

	logic               grant;
	logic               await_rq;
	logic               release_cyc;
	logic               timer_load;
	logic               timer_done;
	logic [timer_w-1:0] timer_count;
	port_vec_t          active;
	port_idx_t          active_port;
	logic               latch_addr;
	logic               strobe_sense;
	logic               capture_wr;
	logic               write_core;
	logic               restore;
	addr_t              ma_sel;
	word_t              mb_sel;
	word_t              sense;

	assign ma_sel = ma[active_port];
	assign mb_sel = mb_in[active_port];

	// sense goes out only to the port being served, only during rd_rs
	always_comb begin
		for (int i = 0; i < num_ports; i++) begin
			mb_out[i] = rd_rs[i] ? sense : '0;
		end
	end

	port_arbiter u_arb (
		.clk         (clk),
		.reset       (reset),
		.rq_cyc      (rq_cyc),
		.fmc_select  (fmc_select),
		.sel         (sel),
		.my_sel      (mem_select),
		.await_rq    (await_rq),
		.release_cyc (release_cyc),
		.grant       (grant),
		.active      (active),
		.active_port (active_port)
	);

	cycle_timer u_timer (
		.clk   (clk),
		.reset (reset),
		.load  (timer_load),
		.count (timer_count),
		.done  (timer_done)
	);

	cycle_control u_ctl (
		.clk            (clk),
		.reset          (reset),
		.grant          (grant),
		.active         (active),
		.active_port    (active_port),
		.rd_rq          (rd_rq),
		.wr_rq          (wr_rq),
		.wr_rs          (wr_rs),
		.timer_done     (timer_done),
		.sw_single_step (sw_single_step),
		.sw_restart     (sw_restart),
		.await_rq       (await_rq),
		.release_cyc    (release_cyc),
		.timer_load     (timer_load),
		.timer_count    (timer_count),
		.addr_ack       (addr_ack),
		.rd_rs          (rd_rs),
		.latch_addr     (latch_addr),
		.strobe_sense   (strobe_sense),
		.capture_wr     (capture_wr),
		.write_core     (write_core),
		.restore        (restore)
	);

	core_array u_core (
		.clk          (clk),
		.reset        (reset),
		.ma_sel       (ma_sel),
		.mb_sel       (mb_sel),
		.latch_addr   (latch_addr),
		.strobe_sense (strobe_sense),
		.capture_wr   (capture_wr),
		.write_core   (write_core),
		.restore      (restore),
		.sense        (sense)
	);

endmodule

// File: test/core_checker.sv
`timescale 1ns/100ps

module core_checker #(
	parameter core_pkg::sel_t mem_select = 4'd0
) (
	input logic                                      clk,
	input logic                                      reset,
	input core_pkg::port_vec_t                       rq_cyc,
	input core_pkg::port_vec_t                       rd_rq,
	input core_pkg::port_vec_t                       wr_rq,
	input core_pkg::port_vec_t                       wr_rs,
	input core_pkg::port_vec_t                       fmc_select,
	input core_pkg::sel_t  [core_pkg::num_ports-1:0] sel,
	input core_pkg::addr_t [core_pkg::num_ports-1:0] ma,
	input core_pkg::word_t [core_pkg::num_ports-1:0] mb_in,
	input core_pkg::port_vec_t                       addr_ack,
	input core_pkg::port_vec_t                       rd_rs,
	input core_pkg::word_t [core_pkg::num_ports-1:0] mb_out
);
	import core_pkg::*;

	word_t     shadow [addr_t];
	port_vec_t q_prev1;
	port_vec_t q_prev2;	// requests seen when the winner was picked
	logic      alt3;	// port 3 served last
	int        cur_port;
	addr_t     cur_addr;
	logic      cur_rd;
	logic      cur_wr;
	logic      rd_taken;
	logic      wr_taken;
	int        error_count = 0;
	int        error_mark = 0;
	int        n_tests = 0;
	int        n_passed = 0;

	function automatic port_vec_t qualify(input port_vec_t rq, input port_vec_t fmc,
			input sel_t [num_ports-1:0] s);
		port_vec_t q;
		for (int i = 0; i < num_ports; i++) begin
			q[i] = rq[i] && !fmc[i] && (s[i] == mem_select);
		end
		return q;
	endfunction

	function automatic port_vec_t predict_winner(input port_vec_t q, input logic last3);
		if (q[0]) return 4'b0001;
		if (q[1]) return 4'b0010;
		if (q[2] && q[3]) return last3 ? 4'b0100 : 4'b1000;
		if (q[2]) return 4'b0100;
		if (q[3]) return 4'b1000;
		return 4'b0000;
	endfunction

	function automatic word_t expect_word(input addr_t a);
		if (shadow.exists(a)) return shadow[a];
		return 'x;	// core word unknown until first written
	endfunction

	task automatic report_mismatch(input string msg);
		$display("FAIL %0t ns: %s", $time, msg);
		error_count++;
	endtask

	task automatic report_problem(input string msg);
		$display("%s (at %0t ns)", msg, $time);
		error_count++;
	endtask

	task automatic end_test(input string name);
		n_tests++;
		if (error_count == error_mark) begin
			n_passed++;
			$display("PASS %0t ns: test %0d %s", $time, n_tests, name);
		end else begin
			$display("FAIL %0t ns: test %0d %s, %0d errors", $time, n_tests, name,
				error_count - error_mark);
		end
		error_mark = error_count;
	endtask

	task automatic final_report();
		$display("%0d tests run, %0d passed, %0d failed, %0d errors", n_tests, n_passed,
			n_tests - n_passed, error_count);
	endtask

	// outputs are settled at the falling edge
	always @(negedge clk) begin
		port_vec_t expect_ack;
		if (reset) begin
			q_prev1  = '0;
			q_prev2  = '0;
			alt3     = 1'b0;
			cur_port = 0;
			cur_rd   = 1'b0;
			cur_wr   = 1'b0;
			rd_taken = 1'b0;
			wr_taken = 1'b0;
		end else begin
			if (|addr_ack) begin
				expect_ack = predict_winner(q_prev2, alt3);
				if (addr_ack !== expect_ack) begin
					report_mismatch($sformatf("addr_ack %b, expected %b", addr_ack, expect_ack));
				end
				if (expect_ack[3:2] != 2'b00) alt3 = expect_ack[3];
				for (int i = 0; i < num_ports; i++) begin
					if (addr_ack[i]) cur_port = i;
				end
				cur_addr = ma[cur_port];
				cur_rd   = rd_rq[cur_port];
				cur_wr   = wr_rq[cur_port];
				rd_taken = 1'b0;
				wr_taken = 1'b0;
			end
			if (rd_rs[cur_port]) begin
				if (!cur_rd || rd_taken) begin
					report_mismatch($sformatf("rd_rs on port %0d without a pending read",
						cur_port));
				end
				if (mb_out[cur_port] !== expect_word(cur_addr)) begin
					report_mismatch($sformatf("port %0d read %h at %h, expected %h", cur_port,
						mb_out[cur_port], cur_addr, expect_word(cur_addr)));
				end
				rd_taken = 1'b1;
			end
			if (wr_rs[cur_port] && cur_wr && !wr_taken) begin
				shadow[cur_addr] = mb_in[cur_port];	// first write restart of the cycle
				wr_taken = 1'b1;
			end
			for (int i = 0; i < num_ports; i++) begin
				if (rd_rs[i] && i != cur_port) begin
					report_mismatch($sformatf("rd_rs on idle port %0d", i));
				end
				if (!rd_rs[i] && mb_out[i] !== '0) begin
					report_mismatch($sformatf("mb_out of port %0d is %h outside rd_rs", i,
						mb_out[i]));
				end
			end
			q_prev2 = q_prev1;
			q_prev1 = qualify(rq_cyc, fmc_select, sel);
		end
	end

endmodule

// File: test/core_memory_tb.sv
`timescale 1ns/100ps

module core_memory_tb;
	import core_pkg::*;

	localparam sel_t my_sel      = 4'd5;
	localparam int   n_words     = 32;
	localparam int   n_cycles    = 120;	// memory cycles over all tests
	localparam int   worst_cycle = 40;	// clocks incl. arbitration and write wait
	localparam int   cycle_limit = n_cycles * worst_cycle + 100;

	logic                  clk = 1'b0;
	logic                  reset;
	logic                  sw_single_step;
	logic                  sw_restart;
	port_vec_t             rq_cyc;
	port_vec_t             rd_rq;
	port_vec_t             wr_rq;
	port_vec_t             wr_rs;
	port_vec_t             fmc_select;
	sel_t  [num_ports-1:0] sel;
	addr_t [num_ports-1:0] ma;
	word_t [num_ports-1:0] mb_in;
	port_vec_t             addr_ack;
	port_vec_t             rd_rs;
	word_t [num_ports-1:0] mb_out;
	logic [31:0]           rng = 32'ha2d8;
	int                    cycle_cnt = 0;
	addr_t                 addr_q [n_words];

	core_memory #(.mem_select(my_sel)) dut0 (.*);

	core_checker #(.mem_select(my_sel)) chk0 (
		.clk(clk), .reset(reset), .rq_cyc(rq_cyc), .rd_rq(rd_rq), .wr_rq(wr_rq),
		.wr_rs(wr_rs), .fmc_select(fmc_select), .sel(sel), .ma(ma), .mb_in(mb_in),
		.addr_ack(addr_ack), .rd_rs(rd_rs), .mb_out(mb_out)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout: the DUT stopped answering after %0d clock cycles", cycle_cnt);
			$display("tests failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic word_t rand_word();
		logic [31:0] hi;
		rng = xorshift(rng);
		hi  = rng;
		rng = xorshift(rng);
		return {hi[3:0], rng};
	endfunction

	// one processor memory cycle on port p
	task automatic run_cycle(input int p, input sel_t s, input addr_t a, input logic rd,
			input logic wr, input word_t d, input int wr_delay);
		@(posedge clk);
		#1;
		rq_cyc[p] = 1'b1;
		sel[p]    = s;
		ma[p]     = a;
		rd_rq[p]  = rd;
		wr_rq[p]  = wr;
		while (!addr_ack[p]) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
		rq_cyc[p] = 1'b0;
		rd_rq[p]  = 1'b0;
		wr_rq[p]  = 1'b0;
		while (rd && !rd_rs[p]) begin
			@(posedge clk);
			#1;
		end
		if (wr) begin
			repeat (wr_delay) begin
				@(posedge clk);
				#1;
			end
			mb_in[p] = d;
			wr_rs[p] = 1'b1;
			@(posedge clk);
			#1;
			wr_rs[p] = 1'b0;
			mb_in[p] = '0;
		end
	endtask

	initial begin
		reset          = 1'b1;
		sw_single_step = 1'b0;
		sw_restart     = 1'b0;
		rq_cyc         = '0;
		rd_rq          = '0;
		wr_rq          = '0;
		wr_rs          = '0;
		fmc_select     = '0;
		sel            = '0;
		ma             = '0;
		mb_in          = '0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		for (int i = 0; i < n_words; i++) begin
			addr_q[i] = addr_t'(rand_word());
			run_cycle(i % num_ports, my_sel, addr_q[i], 1'b0, 1'b1, rand_word(), 0);
		end
		for (int i = 0; i < n_words; i++) begin
			run_cycle((i + 1) % num_ports, my_sel, addr_q[i], 1'b1, 1'b0, '0, 0);
		end
		chk0.end_test("write then read");

		for (int i = 0; i < 4; i++) begin
			run_cycle(i, my_sel, addr_q[i], 1'b1, 1'b1, rand_word(), 1 + 3 * i);	// longer waits
			run_cycle(3 - i, my_sel, addr_q[i], 1'b1, 1'b0, '0, 0);
		end
		chk0.end_test("read-modify-write");

		for (int i = 4; i < 8; i++) begin
			repeat (2) run_cycle(i % num_ports, my_sel, addr_q[i], 1'b1, 1'b0, '0, 0);
		end
		chk0.end_test("read restores the word");

		repeat (3) begin
			fork
				run_cycle(0, my_sel, addr_q[8], 1'b1, 1'b0, '0, 0);
				run_cycle(1, my_sel, addr_q[9], 1'b1, 1'b0, '0, 0);
				run_cycle(2, my_sel, addr_q[10], 1'b1, 1'b0, '0, 0);
				run_cycle(3, my_sel, addr_q[11], 1'b1, 1'b0, '0, 0);
			join
		end
		fork
			repeat (4) run_cycle(2, my_sel, addr_q[12], 1'b1, 1'b0, '0, 0);
			repeat (4) run_cycle(3, my_sel, addr_q[13], 1'b0, 1'b1, rand_word(), 0);
		join
		chk0.end_test("arbitration");

		fmc_select[2] = 1'b1;	// port 2 belongs to the fast memory
		rq_cyc[2]     = 1'b1;
		sel[2]        = my_sel;
		rq_cyc[3]     = 1'b1;
		sel[3]        = my_sel + 4'd1;
		repeat (2) begin
			fork
				run_cycle(0, my_sel, addr_q[14], 1'b1, 1'b0, '0, 0);
				run_cycle(1, my_sel, addr_q[15], 1'b1, 1'b0, '0, 0);
			join
		end
		repeat (12) @(posedge clk);
		#1;
		rq_cyc[3:2]   = 2'b00;
		fmc_select[2] = 1'b0;
		chk0.end_test("unselected requests");

		sw_single_step = 1'b1;
		run_cycle(1, my_sel, addr_q[2], 1'b1, 1'b0, '0, 0);
		sw_single_step = 1'b0;
		fork
			run_cycle(2, my_sel, addr_q[3], 1'b1, 1'b0, '0, 0);
			begin
				repeat (30) begin
					@(posedge clk);
					#1;
					if (addr_ack[2]) begin
						chk0.report_problem("port 2 was acknowledged while the memory was stopped");
					end
				end
				sw_restart = 1'b1;	// key restart
				repeat (2) @(posedge clk);
				#1;
				sw_restart = 1'b0;
			end
		join
		chk0.end_test("single step");

		repeat (20) @(posedge clk);
		chk0.final_report();
		if (chk0.error_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: flist.f
design/core_pkg.sv
design/port_arbiter.sv
design/cycle_timer.sv
design/cycle_control.sv
design/core_array.sv
design/core_memory.sv
test/core_checker.sv
test/core_memory_tb.sv

// File: Bender.yml
package:
  name: core_memory

sources:
  - design/core_pkg.sv
  - design/port_arbiter.sv
  - design/cycle_timer.sv
  - design/cycle_control.sv
  - design/core_array.sv
  - design/core_memory.sv
  - target: test
    files:
      - test/core_checker.sv
      - test/core_memory_tb.sv
